// File: sources.f
+incdir+common
common/rsa_pkg.sv
rsa256_core/rsa_modprod.sv
rsa256_core/rsa_mont.sv
rsa256_core/rsa256_core.sv
source/rsa256_wrapper.sv
testbench/rsa_avm_asserts.sv
testbench/tb_rsa.sv

// File: run_sim.sh
#!/bin/sh
# builds the rsa256 testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_rsa_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_rsa -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0

// File: testbench/tb_rsa.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

module tb_rsa;
    import rsa_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'ha7adf2b3;
    localparam int          num_msgs  = 3;
    // byte polls plus core time per message, at 20 ns per cycle
    localparam longint watchdog_ns = (num_msgs * (96 + 62) * 16 + num_msgs * 70000) * 20;

    logic        avm_clk         = 1'b0;
    logic        avm_rst         = 1'b1;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata    = 32'd0;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b1;

    logic [31:0] lfsr         = lfsr_seed;
    logic [3:0]  reset_count  = 4'd0;
    logic [7:0]  rx_q[$];     // bytes the uart still has to deliver
    logic [7:0]  exp_q[$];    // bytes expected on tx, in order
    logic [7:0]  last_status  = 8'd0;
    logic        status_valid = 1'b0;
    logic        first_done   = 1'b0;
    int          rx_reads     = 0;
    int          tx_count     = 0;
    int          messages_done = 0;

    rsa256_wrapper dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    bind rsa256_wrapper rsa_avm_asserts u_avm_asserts (
        .clk           (avm_clk),
        .rst           (avm_rst),
        .address       (avm_address),
        .read          (avm_read),
        .write         (avm_write),
        .writedata     (avm_writedata),
        .waitrequest   (avm_waitrequest),
        .core_start    (core_start),
        .core_finished (core_finished)
    );

    always #10 avm_clk = ~avm_clk;

    always @(posedge avm_clk) begin
        if (reset_count != 4'd8) reset_count <= reset_count + 4'd1;
        avm_rst <= (reset_count < 4'd7);   // high for the first 8 cycles
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic rsa_word_t random_word();
        rsa_word_t w;
        for (int i = 0; i < `RSA_BITS; i++) w[i] = next_bit();
        return w;
    endfunction

    function automatic void push_bytes(input rsa_word_t w);
        for (int i = `RSA_IN_BYTES - 1; i >= 0; i--) rx_q.push_back(w[i*8 +: 8]);
    endfunction

    // x * y mod m by shift and add, msb of y first
    function automatic rsa_word_t mod_mul(input rsa_word_t x, input rsa_word_t y,
                                          input rsa_word_t m);
        logic [`RSA_BITS+1:0] r;
        r = '0;
        for (int i = `RSA_BITS - 1; i >= 0; i--) begin
            r = r << 1;
            if (r >= {2'b00, m}) r = r - {2'b00, m};
            if (y[i]) begin
                r = r + {2'b00, x};
                if (r >= {2'b00, m}) r = r - {2'b00, m};
            end
        end
        return r[`RSA_BITS-1:0];
    endfunction

    task automatic mod_exp(input rsa_word_t base_in, input rsa_word_t exp_in,
                           input rsa_word_t m, output rsa_word_t r);
        rsa_word_t base;
        r    = rsa_word_t'(1);
        base = base_in;
        for (int i = 0; i < `RSA_BITS; i++) begin
            if (exp_in[i]) r = mod_mul(r, base, m);
            base = mod_mul(base, base, m);
        end
    endtask

    ////////////////////
    // uart register model
    ////////////////////

    function automatic logic [31:0] read_response(input logic [4:0] address, input logic read);
        logic [31:0] data;
        logic        rx_bit;
        logic        tx_bit;
        data = 32'd0;
        if (read && address == `AVM_STATUS_ADDR) begin
            rx_bit = next_bit();
            tx_bit = next_bit();
            data[`AVM_RX_OK_BIT] = rx_bit && (rx_q.size() != 0);   // nothing to offer when empty
            data[`AVM_TX_OK_BIT] = tx_bit;
        end else if (read && address == `AVM_RX_ADDR && rx_q.size() != 0) begin
            data[7:0] = rx_q[0];
        end
        return data;
    endfunction

    task automatic handle_transfer();
        logic [7:0] expected;
        if (!first_done) begin
            first_done = 1'b1;
            assert (avm_read && avm_address == `AVM_STATUS_ADDR)
                else stop_with_failure("first transfer after reset is not a status read");
        end
        if (avm_read && avm_address == `AVM_STATUS_ADDR) begin
            last_status  = avm_readdata[7:0];
            status_valid = 1'b1;
        end else if (avm_read && avm_address == `AVM_RX_ADDR) begin
            assert (status_valid && last_status[`AVM_RX_OK_BIT])
                else stop_with_failure("RX read without a status read showing rx_ok before it");
            void'(rx_q.pop_front());
            rx_reads++;
            status_valid = 1'b0;
        end else if (avm_write && avm_address == `AVM_TX_ADDR) begin
            assert (status_valid && last_status[`AVM_TX_OK_BIT])
                else stop_with_failure("TX write without a status read showing tx_ok before it");
            expected = exp_q.pop_front();
            assert (avm_writedata == {24'd0, expected})
                else stop_with_failure($sformatf("[FAIL] avm_writedata expected 0x%08h got 0x%08h",
                                                 {24'd0, expected}, avm_writedata));
            tx_count++;
            if (tx_count % `RSA_OUT_BYTES == 0) messages_done++;
            status_valid = 1'b0;
        end else begin
            stop_with_failure($sformatf("transfer to an unknown address 0x%02h", avm_address));
        end
    endtask

    // a new command always sees one wait cycle, then the lfsr decides
    always @(posedge avm_clk) begin
        logic stall;
        stall = next_bit();
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
            avm_readdata    <= 32'd0;
        end else begin
            if ((avm_read || avm_write) && !avm_waitrequest) handle_transfer();
            if ((avm_read || avm_write) && avm_waitrequest && !stall) begin
                avm_waitrequest <= 1'b0;
                avm_readdata    <= read_response(avm_address, avm_read);
            end else begin
                avm_waitrequest <= 1'b1;
                avm_readdata    <= 32'd0;
            end
        end
    end

    ////////////////////
    // stimulus and end of run
    ////////////////////

    initial begin
        rsa_word_t n_key;
        rsa_word_t d_key;
        rsa_word_t a_msg;
        rsa_word_t plain;
        logic      all_seen;
        n_key = random_word();
        n_key[0] = 1'b1;
        n_key[`RSA_BITS-1:`RSA_BITS-2] = 2'b00;
        d_key = random_word();
        push_bytes(n_key);
        push_bytes(d_key);   // keys go out once only
        for (int msg = 0; msg < num_msgs; msg++) begin
            a_msg = random_word();
            while (a_msg >= n_key) a_msg = a_msg - n_key;
            push_bytes(a_msg);
            mod_exp(a_msg, d_key, n_key, plain);
            for (int b = `RSA_OUT_BYTES - 1; b >= 0; b--) exp_q.push_back(plain[b*8 +: 8]);
        end
        wait (messages_done == num_msgs);
        all_seen = (rx_reads == 2 * `RSA_IN_BYTES + num_msgs * `RSA_IN_BYTES);
        if (all_seen) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_with_failure($sformatf("wrong number of RX reads (%0d)", rx_reads));
        end
    end

    initial begin
        #(watchdog_ns);
        stop_with_failure("run timed out before all three results were written");
    end

endmodule

// File: testbench/rsa_avm_asserts.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

// protocol checks on the avalon master side of the wrapper and on the core strobes
module rsa_avm_asserts (
    input logic        clk,
    input logic        rst,
    input logic [4:0]  address,
    input logic        read,
    input logic        write,
    input logic [31:0] writedata,
    input logic        waitrequest,
    input logic        core_start,
    input logic        core_finished
);
    import rsa_pkg::*;

    avm_cmd_t command;

    assign command = '{address: address, read: read, write: write, writedata: writedata};

    a_no_read_write: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else $error("read and write are high in the same cycle");

    // a stalled command has to wait for the slave
    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        (command.read || command.write) && waitrequest |=> $stable(command))
        else $error("command changed while waitrequest was high");

    a_start_pulse: assert property (@(posedge clk) disable iff (rst) core_start |=> !core_start)
        else $error("core start is longer than one cycle");

    a_finished_pulse: assert property (@(posedge clk) disable iff (rst)
        core_finished |=> !core_finished)
        else $error("core finished is longer than one cycle");

    a_idle_in_reset: assert property (@(posedge clk) rst |-> !read && !write)
        else $error("read or write is high during reset");

endmodule

// File: source/rsa256_wrapper.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa256_wrapper (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);
    import rsa_pkg::*;

    typedef enum logic [2:0] {
        poll_rx,
        get_n,
        get_d,
        get_a,
        calc,
        poll_tx,
        send
    } wrap_state_t;

    wrap_state_t   state;
    wrap_state_t   next_get;   // operand the next received byte belongs to
    avm_cmd_t      cmd;
    logic [4:0]    byte_cnt;
    rsa_word_t     n_r;
    rsa_word_t     d_r;
    rsa_word_t     a_r;
    rsa_word_t     result_r;
    rsa_operands_t operands;
    rsa_word_t     core_result;
    logic          core_start;
    logic          core_finished;

    ////////////////////
    // command helpers
    ////////////////////

    function automatic avm_cmd_t cmd_idle();
        return '{address: `AVM_STATUS_ADDR, read: 1'b0, write: 1'b0, writedata: 32'd0};
    endfunction

    function automatic avm_cmd_t status_read();
        return '{address: `AVM_STATUS_ADDR, read: 1'b1, write: 1'b0, writedata: 32'd0};
    endfunction

    function automatic avm_cmd_t rx_read();
        return '{address: `AVM_RX_ADDR, read: 1'b1, write: 1'b0, writedata: 32'd0};
    endfunction

    function automatic avm_cmd_t tx_write(input logic [7:0] data);
        return '{address: `AVM_TX_ADDR, read: 1'b0, write: 1'b1, writedata: {24'd0, data}};
    endfunction

    assign avm_address   = cmd.address;
    assign avm_read      = cmd.read;
    assign avm_write     = cmd.write;
    assign avm_writedata = cmd.writedata;

    assign operands = '{a: a_r, d: d_r, n: n_r};

    rsa256_core u_core (
        .clk      (avm_clk),
        .rst      (avm_rst),
        .start    (core_start),
        .operands (operands),
        .result   (core_result),
        .finished (core_finished)
    );

    ////////////////////
    // master FSM
    ////////////////////

    // a transfer completes in any cycle with the command up and waitrequest low
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= poll_rx;
            next_get   <= get_n;
            byte_cnt   <= '0;
            cmd        <= cmd_idle();
            core_start <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                poll_rx: begin
                    if (!cmd.read) begin
                        cmd <= status_read();   // first poll after reset
                    end else if (!avm_waitrequest && avm_readdata[`AVM_RX_OK_BIT]) begin
                        cmd   <= rx_read();
                        state <= next_get;
                    end
                end
                get_n, get_d, get_a: begin
                    if (!avm_waitrequest) begin
                        byte_cnt <= byte_cnt + 5'd1;
                        cmd      <= status_read();
                        state    <= poll_rx;
                        if (byte_cnt == 5'(`RSA_IN_BYTES - 1)) begin
                            byte_cnt <= '0;
                            if (state == get_n) begin
                                next_get <= get_d;
                            end else if (state == get_d) begin
                                next_get <= get_a;   // keys stay loaded from here on
                            end else begin
                                cmd        <= cmd_idle();
                                state      <= calc;
                                core_start <= 1'b1;
                            end
                        end
                    end
                end
                calc: begin
                    if (core_finished) begin
                        cmd   <= status_read();
                        state <= poll_tx;
                    end
                end
                poll_tx: begin
                    if (!avm_waitrequest && avm_readdata[`AVM_TX_OK_BIT]) begin
                        cmd   <= tx_write(result_r[247:240]);
                        state <= send;
                    end
                end
                default: begin   // send
                    if (!avm_waitrequest) begin
                        byte_cnt <= byte_cnt + 5'd1;
                        cmd      <= status_read();
                        state    <= poll_tx;
                        if (byte_cnt == 5'(`RSA_OUT_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state    <= poll_rx;
                        end
                    end
                end
            endcase
        end
    end

    // the first byte received ends up most significant
    always_ff @(posedge avm_clk) begin
        if (!avm_waitrequest) begin
            case (state)
                get_n: n_r <= {n_r[`RSA_BITS-9:0], avm_readdata[7:0]};
                get_d: d_r <= {d_r[`RSA_BITS-9:0], avm_readdata[7:0]};
                get_a: a_r <= {a_r[`RSA_BITS-9:0], avm_readdata[7:0]};
                send:  result_r <= result_r << 8;
                default: ;
            endcase
        end
        if (state == calc && core_finished) result_r <= core_result;
    end

endmodule

// File: rsa256_core/rsa256_core.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

module rsa256_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  rsa_pkg::rsa_operands_t operands,
    output rsa_pkg::rsa_word_t     result,
    output logic                   finished
);
    import rsa_pkg::*;

    core_state_t state;
    rsa_word_t   n_r;
    rsa_word_t   d_r;    // shifts right, bit 0 is the current exponent bit
    rsa_word_t   t_r;    // a^(2^i) in montgomery form
    rsa_word_t   m_r;    // running product
    rsa_word_t   prep_result;
    rsa_word_t   sqr_result;
    rsa_word_t   mul_result;
    logic        prep_done;
    logic        sqr_done;
    logic        mul_done;
    logic        step_done;
    logic        mont_start;
    logic [7:0]  bit_idx;

    ////////////////////
    // arithmetic units
    ////////////////////

    // a is taken straight from the operands in the start cycle, n from the latched copy after it
    rsa_modprod u_modprod (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .a      (operands.a),
        .n      (n_r),
        .result (prep_result),
        .done   (prep_done)
    );

    rsa_mont mont_sqr (
        .clk    (clk),
        .rst    (rst),
        .start  (mont_start),
        .x      (t_r),
        .y      (t_r),
        .n      (n_r),
        .result (sqr_result),
        .done   (sqr_done)
    );

    rsa_mont mont_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (mont_start),
        .x      (m_r),
        .y      (t_r),
        .n      (n_r),
        .result (mul_result),
        .done   (mul_done)
    );

    assign step_done = sqr_done & mul_done;   // both units have the same latency
    assign finished  = (state == core_done);
    assign result    = m_r;

    ////////////////////
    // controller
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= core_idle;
            mont_start <= 1'b0;
            bit_idx    <= '0;
        end else begin
            mont_start <= 1'b0;
            case (state)
                core_idle: if (start) state <= core_prep;
                core_prep: begin
                    if (prep_done) begin
                        state      <= core_loop;
                        mont_start <= 1'b1;
                        bit_idx    <= '0;
                    end
                end
                core_loop: begin
                    if (step_done) begin
                        bit_idx <= bit_idx + 8'd1;
                        if (bit_idx == 8'(`RSA_BITS - 1)) state <= core_done;
                        else mont_start <= 1'b1;
                    end
                end
                default: state <= core_idle;   // finished is high for this one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_idle && start) begin
            n_r <= operands.n;
            d_r <= operands.d;
        end
        if (state == core_prep && prep_done) begin
            t_r <= prep_result;
            // plain 1, the mont product with t cancels the 2^256 factor
            m_r <= rsa_word_t'(1);
        end
        if (state == core_loop && step_done) begin
            t_r <= sqr_result;
            if (d_r[0]) m_r <= mul_result;
            d_r <= d_r >> 1;
        end
    end

endmodule

// File: rsa256_core/rsa_mont.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

// radix-2 montgomery product x * y * 2^-256 mod n
module rsa_mont (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t x,
    input  rsa_pkg::rsa_word_t y,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic               done
);
    import rsa_pkg::*;

    rsa_word_t            x_sh;   // x, consumed from the lsb
    logic [`RSA_BITS+1:0] acc;
    logic [`RSA_BITS+1:0] sum_y;
    logic [`RSA_BITS+1:0] sum_n;
    logic [`RSA_BITS+1:0] acc_red;
    logic [7:0]           step;
    logic                 busy;
    logic                 fix;    // final conditional subtraction

    ////////////////////
    // one bit per cycle
    ////////////////////

    assign sum_y = x_sh[0] ? acc + {2'b00, y} : acc;
    assign sum_n = sum_y[0] ? sum_y + {2'b00, n} : sum_y;   // makes the sum even
    // acc ends below 2n after the loop
    assign acc_red = (acc >= {2'b00, n}) ? acc - {2'b00, n} : acc;
    assign result  = acc[`RSA_BITS-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            fix  <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            fix  <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 8'd1;
                if (step == 8'(`RSA_BITS - 1)) begin
                    busy <= 1'b0;
                    fix  <= 1'b1;
                end
            end else if (fix) begin
                done <= 1'b1;   // 258 cycles after start
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x_sh <= x;
            acc  <= '0;
        end else if (busy) begin
            x_sh <= x_sh >> 1;
            acc  <= sum_n >> 1;
        end else if (fix) begin
            acc <= acc_red;
        end
    end

endmodule

// File: rsa256_core/rsa_modprod.sv
`timescale 1ns/1ps
`include "rsa_defs.svh"

// brings a into the montgomery domain by repeated doubling
module rsa_modprod (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic               done
);

    logic [`RSA_BITS+1:0] acc;
    logic [`RSA_BITS+1:0] acc_dbl;
    logic [`RSA_BITS+1:0] acc_next;
    logic [7:0]           step;
    logic                 busy;

    // acc stays below n, so the doubled value is below 2n and one subtraction is enough
    assign acc_dbl  = {acc[`RSA_BITS:0], 1'b0};
    assign acc_next = (acc_dbl >= {2'b00, n}) ? acc_dbl - {2'b00, n} : acc_dbl;
    assign result   = acc[`RSA_BITS-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 8'd1;
                if (step == 8'(`RSA_BITS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // 257 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= {2'b00, a};
        end else if (busy) begin
            acc <= acc_next;
        end
    end

endmodule

// File: common/rsa_pkg.sv
`include "rsa_defs.svh"

package rsa_pkg;

    ////////////////////
    // datapath types
    ////////////////////

    typedef logic [`RSA_BITS-1:0] rsa_word_t;

    // everything the core needs for one decryption
    typedef struct packed {
        rsa_word_t a;   // ciphertext
        rsa_word_t d;   // private exponent
        rsa_word_t n;   // modulus
    } rsa_operands_t;

    ////////////////////
    // avalon master
    ////////////////////

    typedef struct packed {
        logic [4:0]  address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avm_cmd_t;

    typedef enum logic [1:0] {
        core_idle,
        core_prep,   // a * 2^256 mod n in progress
        core_loop,   // square and multiply over the bits of d
        core_done
    } core_state_t;

endpackage

// File: common/rsa_defs.svh
`ifndef RSA_DEFS_SVH
`define RSA_DEFS_SVH

////////////////////
// key and operand sizes
////////////////////

`define RSA_BITS      256
`define RSA_IN_BYTES  32   // bytes per received operand
`define RSA_OUT_BYTES 31   // the top result byte is never sent

////////////////////
// uart register file
////////////////////

// byte offsets on the 5-bit avalon address
`define AVM_RX_ADDR     5'd0
`define AVM_TX_ADDR     5'd4
`define AVM_STATUS_ADDR 5'd8

`define AVM_TX_OK_BIT 6
`define AVM_RX_OK_BIT 7

`endif
